//--- mod_pkg.sv
`default_nettype none

package mod_pkg;

  localparam int OPERAND_W  = 100;
  localparam int CHUNK_W    = 6;
  localparam int NUM_CHUNKS = 16; // chunks above the low one.
  localparam int RES_W      = 9;
  localparam int SUM_W      = 13;

  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;

  // register map.
  localparam logic [ADDR_W-1:0] REG_OP0    = 8'h00;
  localparam logic [ADDR_W-1:0] REG_OP1    = 8'h04;
  localparam logic [ADDR_W-1:0] REG_OP2    = 8'h08;
  localparam logic [ADDR_W-1:0] REG_OP3    = 8'h0C; // bits 3:0 only.
  localparam logic [ADDR_W-1:0] REG_CTRL   = 8'h10;
  localparam logic [ADDR_W-1:0] REG_STATUS = 8'h14;
  localparam logic [ADDR_W-1:0] REG_RESULT = 8'h18;

  // 2^n mod m, evaluated at elaboration.
  function automatic int pow2_mod(input int n, input int m);
    int r;
    r = 1 % m;
    for (int i = 0; i < n; i++)
      r = (r * 2) % m;
    return r;
  endfunction

endpackage

`default_nettype wire

//--- mod_if.sv
`default_nettype none

interface mod_if
  import mod_pkg::*;
(
  input logic clk
);

  logic [OPERAND_W-1:0] operand; // stable while start is high.
  logic                 start;   // one-cycle pulse.
  logic [RES_W-1:0]     result;  // valid while done is high.
  logic                 done;    // one-cycle pulse.

  modport regs (
    input  clk,
    output operand,
    output start,
    input  result,
    input  done
  );

  modport core (
    input  clk,
    input  operand,
    input  start,
    output result,
    output done
  );

endinterface

`default_nettype wire

//--- chunk_residue.sv
`default_nettype none

module chunk_residue
  import mod_pkg::*;
#(
  parameter int MODULUS = 461,
  parameter int SHIFT   = 0
)
(
  input  logic               clk,
  input  logic               reset,
  input  logic [CHUNK_W-1:0] chunk,
  output logic [RES_W-1:0]   residue
);

  localparam int SCALE = pow2_mod(SHIFT, MODULUS); // weight of this chunk.

  typedef logic [2**CHUNK_W-1:0][RES_W-1:0] table_t;

  // entry v holds v * 2^SHIFT mod MODULUS.
  function automatic table_t build_table();
    table_t t;
    for (int v = 0; v < 2**CHUNK_W; v++)
      t[v] = RES_W'((v * SCALE) % MODULUS);
    return t;
  endfunction

  localparam table_t TABLE = build_table();

  always_ff @(posedge clk)
  begin
    if (reset)
      residue <= '0;
    else
      residue <= TABLE[chunk];
  end

endmodule

`default_nettype wire

//--- residue_fold.sv
`default_nettype none

module residue_fold
  import mod_pkg::*;
#(
  parameter int MODULUS = 461
)
(
  input  logic               clk,
  input  logic               reset,
  input  logic [RES_W-1:0]   residues [NUM_CHUNKS],
  input  logic [CHUNK_W-1:0] low_chunk,
  input  logic               valid_in,
  output logic [RES_W-1:0]   residue,
  output logic               valid_out
);

  localparam int              FOLD_INT = pow2_mod(RES_W, MODULUS); // 51 for 461.
  localparam logic [SUM_W-1:0] FOLD_K  = SUM_W'(FOLD_INT);

  // largest value one fold can give from any input up to b.
  function automatic int fold_max(input int b);
    int hi;
    int full_lo;
    int top_hi;
    hi = b >> RES_W;
    if (hi == 0)
      return b;
    full_lo = 2**RES_W - 1 + (hi - 1) * FOLD_INT;
    top_hi  = b - hi * (2**RES_W - FOLD_INT);
    return (full_lo > top_hi) ? full_lo : top_hi;
  endfunction

  // folds needed in stage 2 before one subtraction is enough.
  function automatic int stage2_folds();
    int b;
    int n;
    b = fold_max(NUM_CHUNKS * (MODULUS - 1)) + 2**CHUNK_W - 1;
    n = 0;
    while (b >= 2 * MODULUS)
    begin
      b = fold_max(b);
      n++;
    end
    return n;
  endfunction

  localparam int NUM_FOLDS = stage2_folds(); // one for 461.

  function automatic logic [SUM_W-1:0] fold(input logic [SUM_W-1:0] x);
    return SUM_W'(x[RES_W-1:0]) + SUM_W'(x[SUM_W-1:RES_W]) * FOLD_K;
  endfunction

  logic [SUM_W-1:0] sum;
  logic [SUM_W-1:0] fold1_q;
  logic             valid1_q;
  logic [SUM_W-1:0] folded;
  logic [SUM_W-1:0] corrected;

  always_comb
  begin
    sum = '0;
    for (int i = 0; i < NUM_CHUNKS; i++)
      sum = sum + SUM_W'(residues[i]);
  end

  always_ff @(posedge clk)
  begin
    fold1_q <= fold(sum) + SUM_W'(low_chunk); // low chunk needs no table.
    if (reset)
      valid1_q <= 1'b0;
    else
      valid1_q <= valid_in;
  end

  always_comb
  begin
    folded = fold1_q;
    for (int i = 0; i < NUM_FOLDS; i++)
      folded = fold(folded);
  end

  assign corrected = (folded >= SUM_W'(MODULUS)) ? folded - SUM_W'(MODULUS) : folded;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      residue   <= '0;
      valid_out <= 1'b0;
    end
    else
    begin
      residue   <= corrected[RES_W-1:0];
      valid_out <= valid1_q;
    end
  end

endmodule

`default_nettype wire

//--- mod_reduce_core.sv
`default_nettype none

module mod_reduce_core
  import mod_pkg::*;
#(
  parameter int MODULUS = 461
)
(
  input logic clk,
  input logic reset,
  mod_if.core bus
);

  localparam int EXT_W = (NUM_CHUNKS + 1) * CHUNK_W; // top chunk is zero-extended.

  logic [EXT_W-1:0]   operand_ext;
  logic [RES_W-1:0]   residues [NUM_CHUNKS];
  logic [CHUNK_W-1:0] low_chunk_q;
  logic               start_q;

  assign operand_ext = EXT_W'(bus.operand);

  // chunk k+1 sits at bit 6*(k+1) of the operand.
  for (genvar k = 0; k < NUM_CHUNKS; k++)
  begin : g_chunk
    chunk_residue #(
      .MODULUS (MODULUS),
      .SHIFT   (CHUNK_W * (k + 1))
    ) u_chunk (
      .clk     (clk),
      .reset   (reset),
      .chunk   (operand_ext[(k + 1) * CHUNK_W +: CHUNK_W]),
      .residue (residues[k])
    );
  end

  // keeps the low chunk and start in step with the tables.
  always_ff @(posedge clk)
  begin
    low_chunk_q <= operand_ext[CHUNK_W-1:0];
    if (reset)
      start_q <= 1'b0;
    else
      start_q <= bus.start;
  end

  residue_fold #(
    .MODULUS (MODULUS)
  ) u_fold (
    .clk       (clk),
    .reset     (reset),
    .residues  (residues),
    .low_chunk (low_chunk_q),
    .valid_in  (start_q),
    .residue   (bus.result),
    .valid_out (bus.done)
  );

endmodule

`default_nettype wire

//--- apb_mod_regs.sv
`default_nettype none

module apb_mod_regs
  import mod_pkg::*;
#(
  parameter int MODULUS = 461
)
(
  input  logic              clk,
  input  logic              reset,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  logic [DATA_W-1:0] pwdata,
  output logic [DATA_W-1:0] prdata,
  output logic              pready,
  output logic              pslverr,
  mod_if.regs               bus
);

  localparam int TOP_W    = OPERAND_W - 3 * DATA_W; // kept bits of REG_OP3.
  localparam int RESULT_W = $clog2(MODULUS);

  logic [OPERAND_W-1:0] operand_q;
  logic                 start_q;
  logic                 busy_q;
  logic                 done_q;
  logic [RESULT_W-1:0]  result_q;

  logic complete;
  logic addr_hit;
  logic start_req;
  logic start_ok;
  logic wr_en;

  assign pready    = 1'b1; // no wait states.
  assign complete  = psel & penable & pready;
  assign start_req = complete & pwrite & (paddr == REG_CTRL) & pwdata[0];
  assign start_ok  = start_req & ~busy_q;
  assign pslverr   = psel & penable & (~addr_hit | (start_req & busy_q));
  assign wr_en     = complete & pwrite & ~pslverr;

  always_comb
  begin
    addr_hit = 1'b1;
    prdata   = '0;
    case (paddr)
      REG_OP0:    prdata = operand_q[DATA_W-1:0];
      REG_OP1:    prdata = operand_q[2*DATA_W-1:DATA_W];
      REG_OP2:    prdata = operand_q[3*DATA_W-1:2*DATA_W];
      REG_OP3:    prdata = DATA_W'(operand_q[OPERAND_W-1:3*DATA_W]);
      REG_CTRL:   prdata = '0; // write-only.
      REG_STATUS: prdata = DATA_W'({done_q, busy_q});
      REG_RESULT: prdata = DATA_W'(result_q);
      default:    addr_hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      case (paddr)
        REG_OP0: operand_q[DATA_W-1:0]          <= pwdata;
        REG_OP1: operand_q[2*DATA_W-1:DATA_W]   <= pwdata;
        REG_OP2: operand_q[3*DATA_W-1:2*DATA_W] <= pwdata;
        REG_OP3: operand_q[OPERAND_W-1:3*DATA_W] <= pwdata[TOP_W-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      start_q  <= 1'b0;
      busy_q   <= 1'b0;
      done_q   <= 1'b0;
      result_q <= '0;
    end
    else
    begin
      start_q <= start_ok;
      if (start_ok)
      begin
        busy_q <= 1'b1;
        done_q <= 1'b0; // cleared by the next accepted start.
      end
      else if (bus.done)
      begin
        busy_q   <= 1'b0;
        done_q   <= 1'b1;
        result_q <= bus.result[RESULT_W-1:0];
      end
    end
  end

  assign bus.operand = operand_q;
  assign bus.start   = start_q;

endmodule

`default_nettype wire

//--- mod_reduce_top.sv
`default_nettype none

module mod_reduce_top
  import mod_pkg::*;
#(
  parameter int MODULUS = 461
)
(
  input  logic              clk,
  input  logic              reset,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  logic [DATA_W-1:0] pwdata,
  output logic [DATA_W-1:0] prdata,
  output logic              pready,
  output logic              pslverr
);

  mod_if bus (.clk(clk));

  apb_mod_regs #(
    .MODULUS (MODULUS)
  ) u_regs (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .bus     (bus)
  );

  mod_reduce_core #(
    .MODULUS (MODULUS)
  ) u_core (
    .clk   (clk),
    .reset (reset),
    .bus   (bus)
  );

endmodule

`default_nettype wire

//--- mod_reduce_properties.sv
`default_nettype none

module mod_reduce_properties
  import mod_pkg::*;
#(
  parameter int MODULUS = 461
)
(
  input logic             clk,
  input logic             reset,
  input logic             start,
  input logic             done,
  input logic [RES_W-1:0] result
);
  timeunit 1ns;
  timeprecision 1ps;

  // three registered stages between start and done.
  a_done_latency: assert property (@(posedge clk) disable iff (reset) start |-> ##3 done)
    else $error("done did not follow start after three cycles");

  a_done_source: assert property (@(posedge clk) disable iff (reset) done |-> $past(start, 3))
    else $error("done without a start three cycles earlier");

  a_result_range: assert property (@(posedge clk) disable iff (reset)
    done |-> result < RES_W'(MODULUS))
    else $error("result not reduced below the modulus");

  // only one operation in flight.
  a_single_op: assert property (@(posedge clk) disable iff (reset)
    start |-> !($past(start, 1) || $past(start, 2) || $past(start, 3)))
    else $error("start while an operation is in flight");

endmodule

bind mod_reduce_core mod_reduce_properties #(.MODULUS(MODULUS)) u_props (
  .clk    (clk),
  .reset  (reset),
  .start  (bus.start),
  .done   (bus.done),
  .result (bus.result)
);

`default_nettype wire

//--- tb_mod_reduce.sv
`default_nettype none

module tb_mod_reduce
  import mod_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MODULUS        = 461;
  localparam int NUM_TRANSFERS  = 520; // rough count over all tests.
  localparam int TIMEOUT_CYCLES = 20 * NUM_TRANSFERS + 200;

  logic              clk;
  logic              reset;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [ADDR_W-1:0] paddr;
  logic [DATA_W-1:0] pwdata;
  logic [DATA_W-1:0] prdata;
  logic              pready;
  logic              pslverr;

  logic [31:0]          lfsr_state;
  logic [OPERAND_W-1:0] last_operand;
  int                   cycle_count;

  mod_reduce_top #(
    .MODULUS (MODULUS)
  ) dut0 (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #5 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
    end
  end

  task automatic check(input string name, input logic [DATA_W-1:0] actual,
                       input logic [DATA_W-1:0] expected);
    if (actual !== expected)
    begin
      $display("Fail %s: actual 0x%0h, expected 0x%0h", name, actual, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic next_operand(output logic [OPERAND_W-1:0] op);
    for (int i = 0; i < OPERAND_W; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      op[i]      = lfsr_state[0];
    end
  endtask

  function automatic logic [DATA_W-1:0] expected_residue(input logic [OPERAND_W-1:0] op);
    logic [OPERAND_W-1:0] r;
    r = op % OPERAND_W'(MODULUS);
    return DATA_W'(r);
  endfunction

  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    err = pslverr; // completing edge.
    check("pready", DATA_W'(pready), 32'h1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                          output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    data = prdata;
    err  = pslverr;
    check("pready", DATA_W'(pready), 32'h1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_operand(input logic [OPERAND_W-1:0] op);
    logic err;
    apb_write(REG_OP0, op[31:0], err);
    check("pslverr", DATA_W'(err), 32'h0);
    apb_write(REG_OP1, op[63:32], err);
    check("pslverr", DATA_W'(err), 32'h0);
    apb_write(REG_OP2, op[95:64], err);
    check("pslverr", DATA_W'(err), 32'h0);
    apb_write(REG_OP3, DATA_W'(op[OPERAND_W-1:96]), err);
    check("pslverr", DATA_W'(err), 32'h0);
  endtask

  task automatic check_operand_regs(input logic [OPERAND_W-1:0] op);
    logic [DATA_W-1:0] rd;
    logic              err;
    apb_read(REG_OP0, rd, err);
    check("op0", rd, op[31:0]);
    apb_read(REG_OP1, rd, err);
    check("op1", rd, op[63:32]);
    apb_read(REG_OP2, rd, err);
    check("op2", rd, op[95:64]);
    apb_read(REG_OP3, rd, err);
    check("op3", rd, DATA_W'(op[OPERAND_W-1:96]));
  endtask

  task automatic start_operation();
    logic err;
    apb_write(REG_CTRL, 32'h1, err);
    check("pslverr", DATA_W'(err), 32'h0);
  endtask

  task automatic wait_done();
    logic [DATA_W-1:0] rd;
    logic              err;
    rd = '0;
    while (!rd[1])
      apb_read(REG_STATUS, rd, err);
    check("status", rd, 32'h2);
  endtask

  task automatic check_result(input logic [OPERAND_W-1:0] op);
    logic [DATA_W-1:0] rd;
    logic              err;
    apb_read(REG_RESULT, rd, err);
    check("result", rd, expected_residue(op));
    last_operand = op;
  endtask

  task automatic run_operation(input logic [OPERAND_W-1:0] op);
    write_operand(op);
    start_operation();
    wait_done();
    check_result(op);
  endtask

  task automatic test_reset_and_readback();
    logic [DATA_W-1:0] rd;
    logic              err;
    apb_read(REG_STATUS, rd, err);
    check("status", rd, 32'h0);
    check("pslverr", DATA_W'(err), 32'h0);
    apb_read(REG_RESULT, rd, err);
    check("result", rd, 32'h0);
    write_operand({4'hA, 32'h89AB_CDEF, 32'h0123_4567, 32'hDEAD_BEEF});
    check_operand_regs({4'hA, 32'h89AB_CDEF, 32'h0123_4567, 32'hDEAD_BEEF});
    apb_write(REG_OP3, 32'hFFFF_FFF5, err); // upper bits are dropped.
    apb_read(REG_OP3, rd, err);
    check("op3", rd, 32'h5);
  endtask

  task automatic test_edge_operands();
    run_operation(OPERAND_W'(0));
    run_operation(OPERAND_W'(460));
    run_operation(OPERAND_W'(461));
    run_operation(OPERAND_W'(462));
    run_operation(OPERAND_W'(512));
    run_operation({OPERAND_W{1'b1}});
  endtask

  task automatic test_random_operands();
    logic [OPERAND_W-1:0] op;
    for (int n = 0; n < 50; n++)
    begin
      next_operand(op);
      run_operation(op);
    end
  endtask

  task automatic test_busy_refusal();
    logic [OPERAND_W-1:0] op;
    logic [DATA_W-1:0]    rd;
    logic                 err;
    next_operand(op);
    write_operand(op);
    start_operation();
    apb_read(REG_STATUS, rd, err);
    check("status.busy", DATA_W'(rd[0]), 32'h1);
    wait_done();
    check_result(op);
    start_operation();
    apb_write(REG_CTRL, 32'h1, err); // lands while the first is in flight.
    check("pslverr", DATA_W'(err), 32'h1);
    wait_done();
    check_result(op);
  endtask

  task automatic test_unmapped_access();
    logic [DATA_W-1:0] rd;
    logic              err;
    apb_read(8'h1C, rd, err);
    check("pslverr", DATA_W'(err), 32'h1);
    check("prdata", rd, 32'h0);
    apb_write(8'h40, 32'hFFFF_FFFF, err);
    check("pslverr", DATA_W'(err), 32'h1);
    apb_read(8'h40, rd, err);
    check("pslverr", DATA_W'(err), 32'h1);
    check("prdata", rd, 32'h0);
    check_operand_regs(last_operand);
    apb_read(REG_RESULT, rd, err);
    check("result", rd, expected_residue(last_operand));
    apb_read(REG_STATUS, rd, err);
    check("status", rd, 32'h2);
  endtask

  initial
  begin
    clk         = 1'b0;
    reset       = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    lfsr_state  = 32'd11;
    cycle_count = 0;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    test_reset_and_readback();
    test_edge_operands();
    test_random_operands();
    test_busy_refusal();
    test_unmapped_access();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
mod_pkg.sv
mod_if.sv
chunk_residue.sv
residue_fold.sv
mod_reduce_core.sv
apb_mod_regs.sv
mod_reduce_top.sv
mod_reduce_properties.sv
tb_mod_reduce.sv

//--- Makefile
TOP := tb_mod_reduce

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): sim.f $(wildcard *.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -f sim.f

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir
